//--- hdl/dpMemPkg.sv
/* Widths and types shared by the dual-port Wishbone memory
   Memory size is fixed here at 1024 words of 32 bits (4 KiB) */
`default_nettype none

package dpMemPkg;

   localparam int dataWidth   = 32;  // Wishbone and RAM word
   localparam int colWidth    = 8;   // One byte lane
   localparam int numCols     = 4;   // Byte lanes per word
   localparam int ramAdrWidth = 10;  // 1024 words
   localparam int wbAdrWidth  = 32;  // Byte address on the bus

   typedef logic [dataWidth-1:0]   wordT;
   typedef logic [colWidth-1:0]    byteT;
   typedef logic [numCols-1:0]     selT;
   typedef logic [ramAdrWidth-1:0] ramAdrT;
   typedef logic [wbAdrWidth-1:0]  wbAdrT;

   // Port handshake states
   typedef enum logic {
      idle,
      respond
   } portStateT;

endpackage

`default_nettype wire

//--- hdl/dualPortWbMem.sv
/* Dual-ported 4 KiB memory with two independent Wishbone classic slaves
   One cycle from request to response on each port; contents undefined after power-up */
`timescale 1ns/1ps
`default_nettype none

module dualPortWbMem
   import dpMemPkg::*;
(
   input  wire        clk,
   input  wire        arstN,

   // Port A
   input  wire        cycA,
   input  wire        stbA,
   input  wire        weA,
   input  wire wbAdrT adrA,
   input  wire selT   selA,
   input  wire wordT  datWA,
   output wordT       datRA,
   output logic       ackA,
   output logic       errA,

   // Port B
   input  wire        cycB,
   input  wire        stbB,
   input  wire        weB,
   input  wire wbAdrT adrB,
   input  wire selT   selB,
   input  wire wordT  datWB,
   output wordT       datRB,
   output logic       ackB,
   output logic       errB
);

   // RAM side of each port
   logic   ramEnA, ramEnB;
   selT    ramWeA, ramWeB;
   ramAdrT ramAdrA, ramAdrB;
   wordT   ramDinA, ramDinB;
   wordT   ramDoutA, ramDoutB;

   wbMemPort portA (
      .clk     (clk),
      .arstN   (arstN),
      .cyc     (cycA),
      .stb     (stbA),
      .we      (weA),
      .adr     (adrA),
      .sel     (selA),
      .datW    (datWA),
      .datR    (datRA),
      .ack     (ackA),
      .err     (errA),
      .ramEn   (ramEnA),
      .ramWe   (ramWeA),
      .ramAdr  (ramAdrA),
      .ramDin  (ramDinA),
      .ramDout (ramDoutA)
   );

   wbMemPort portB (
      .clk     (clk),
      .arstN   (arstN),
      .cyc     (cycB),
      .stb     (stbB),
      .we      (weB),
      .adr     (adrB),
      .sel     (selB),
      .datW    (datWB),
      .datR    (datRB),
      .ack     (ackB),
      .err     (errB),
      .ramEn   (ramEnB),
      .ramWe   (ramWeB),
      .ramAdr  (ramAdrB),
      .ramDin  (ramDinB),
      .ramDout (ramDoutB)
   );

   tdpRamBe ram (
      .clk   (clk),
      .enA   (ramEnA),
      .weA   (ramWeA),
      .adrA  (ramAdrA),
      .dinA  (ramDinA),
      .doutA (ramDoutA),
      .enB   (ramEnB),
      .weB   (ramWeB),
      .adrB  (ramAdrB),
      .dinB  (ramDinB),
      .doutB (ramDoutB)
   );

endmodule

`default_nettype wire

//--- hdl/tdpRamBe.sv
/* 32-bit true dual-port RAM with byte write enables, read-first
   No address decoding here; same-word writes from both ports are undefined */
`timescale 1ns/1ps
`default_nettype none

module tdpRamBe
   import dpMemPkg::*;
(
   input  wire         clk,

   // Port A
   input  wire         enA,
   input  wire selT    weA,
   input  wire ramAdrT adrA,
   input  wire wordT   dinA,
   output wordT        doutA,

   // Port B
   input  wire         enB,
   input  wire selT    weB,
   input  wire ramAdrT adrB,
   input  wire wordT   dinB,
   output wordT        doutB
);

   // Byte lane i of both ports goes to column i
   for (genvar i = 0; i < numCols; i++) begin : genCol
      tdpRamCol col (
         .clk   (clk),

         .enA   (enA),
         .weA   (weA[i]),
         .adrA  (adrA),
         .dinA  (dinA[i*colWidth +: colWidth]),
         .doutA (doutA[i*colWidth +: colWidth]),

         .enB   (enB),
         .weB   (weB[i]),
         .adrB  (adrB),
         .dinB  (dinB[i*colWidth +: colWidth]),
         .doutB (doutB[i*colWidth +: colWidth])
      );
   end

   /* Overlapping byte writes to one word in the same cycle leave
      the column contents undefined */
   property noWriteCollision;
      @(posedge clk) (enA && enB && (adrA == adrB)) |-> ((weA & weB) == '0);
   endproperty

   assert property (noWriteCollision)
      else $error("Write collision on word %0d, lanes A %b B %b", adrA, weA, weB);

endmodule

`default_nettype wire

//--- hdl/tdpRamCol.sv
/* One byte-wide true dual-port RAM column, read-first on both ports
   Contents are not initialised; both ports writing one address gives undefined data */
`timescale 1ns/1ps
`default_nettype none

module tdpRamCol
   import dpMemPkg::*;
(
   input  wire         clk,

   // Port A
   input  wire         enA,
   input  wire         weA,
   input  wire ramAdrT adrA,
   input  wire byteT   dinA,
   output byteT        doutA,

   // Port B
   input  wire         enB,
   input  wire         weB,
   input  wire ramAdrT adrB,
   input  wire byteT   dinB,
   output byteT        doutB
);

   byteT mem [0:2**ramAdrWidth-1];

   // Port A
   always @(posedge clk) begin
      if (enA) begin
         doutA <= mem[adrA];   // Old contents, read-first
         if (weA) begin
            mem[adrA] <= dinA;
         end
      end
   end

   // Port B, separate block so both ports act in one cycle
   always @(posedge clk) begin
      if (enB) begin
         doutB <= mem[adrB];
         if (weB) begin
            mem[adrB] <= dinB;
         end
      end
   end

endmodule

`default_nettype wire

//--- hdl/wbMemPort.sv
/* Wishbone classic slave for one RAM port, single cycles only, no bursts
   Accesses outside 4 KiB or not word aligned get err and leave the RAM alone */
`timescale 1ns/1ps
`default_nettype none

module wbMemPort
   import dpMemPkg::*;
(
   input  wire         clk,
   input  wire         arstN,

   // Wishbone slave side
   input  wire         cyc,
   input  wire         stb,
   input  wire         we,
   input  wire wbAdrT  adr,
   input  wire selT    sel,
   input  wire wordT   datW,
   output wordT        datR,
   output logic        ack,
   output logic        err,

   // RAM port side
   output logic        ramEn,
   output selT         ramWe,
   output ramAdrT      ramAdr,
   output wordT        ramDin,
   input  wire wordT   ramDout
);

   portStateT state;

   logic request;   // New access seen while idle
   logic addrOk;

   assign request = (state == idle) && cyc && stb;

   // Upper bits above the window and the two byte-offset bits must be zero
   assign addrOk = (adr[wbAdrWidth-1:ramAdrWidth+2] == '0) && (adr[1:0] == 2'b00);

   // RAM is driven straight from the bus during the request cycle
   assign ramEn  = request && addrOk;
   assign ramWe  = sel & {numCols{we && ramEn}};   // Zero mask on reads
   assign ramAdr = adr[ramAdrWidth+1:2];
   assign ramDin = datW;

   // Registered RAM output lines up with ack
   assign datR = ramDout;

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         state <= idle;
         ack   <= 1'b0;
         err   <= 1'b0;
      end else begin
         ack <= 1'b0;   // Response lasts one cycle
         err <= 1'b0;
         case (state)
            idle: begin
               if (request) begin
                  state <= respond;
                  ack   <= addrOk;
                  err   <= !addrOk;
               end
            end
            respond: begin
               // Master drops stb or presents the next access here
               state <= idle;
            end
            default: begin
               state <= idle;
            end
         endcase
      end
   end

   // A response is either ack or err, never both
   property respExclusive;
      @(posedge clk) disable iff (!arstN) !(ack && err);
   endproperty

   assert property (respExclusive)
      else $error("ack and err high together");

   /* The RAM stays idle while a response is on the bus, even with stb
      still high for the next access */
   property noEnInRespond;
      @(posedge clk) disable iff (!arstN) (ack || err) |-> !ramEn;
   endproperty

   assert property (noEnInRespond)
      else $error("RAM enabled during a response cycle");

endmodule

`default_nettype wire

//--- tb/tbDualPortWbMem.sv
/* Testbench for the dual-port Wishbone memory, classic single cycles only
   Concurrent traffic keeps ports A and B in disjoint halves to avoid write collisions */
`timescale 1ns/1ps
`default_nettype none

module tbDualPortWbMem
   import dpMemPkg::*;
();

   logic  clk;
   logic  arstN;
   logic  cycA, stbA, weA, ackA, errA;
   logic  cycB, stbB, weB, ackB, errB;
   wbAdrT adrA, adrB;
   selT   selA, selB;
   wordT  datWA, datWB, datRA, datRB;

   wordT        shadow [0:2**ramAdrWidth-1];   // Expected memory contents
   logic [33:0] expA[$];                       // {err, read, data} per pending access
   logic [33:0] expB[$];
   int          errorCount = 0;
   int          checkCount = 0;
   int          testsFailed = 0;
   int          seedResult;

   dualPortWbMem i_dut (.*);

   always #2 clk = ~clk;   // 4 ns period

   task automatic compare(input string name, input logic [63:0] actual,
                          input logic [63:0] expected);
      checkCount++;
      if (actual !== expected) begin
         errorCount++;
         $display("** Error at %0.1f ns: %s is %0h, expected %0h",
                  $realtime, name, actual, expected);
      end
   endtask

   // Expected word after a write with byte selects
   function automatic wordT mergeBytes(input wordT oldWord, input wordT newWord, input selT sel);
      wordT result;
      result = oldWord;
      for (int i = 0; i < numCols; i++) begin
         if (sel[i]) begin
            result[i*colWidth +: colWidth] = newWord[i*colWidth +: colWidth];
         end
      end
      return result;
   endfunction

   task automatic driveBus(input int port, input bit active, input bit wr,
                           input wbAdrT adr, input selT sel, input wordT data);
      if (port == 0) begin
         cycA  = active;
         stbA  = active;
         weA   = wr;
         adrA  = adr;
         selA  = sel;
         datWA = data;
      end else begin
         cycB  = active;
         stbB  = active;
         weB   = wr;
         adrB  = adr;
         selB  = sel;
         datWB = data;
      end
   endtask

   // Entered and left half a nanosecond after a rising edge
   task automatic busAccess(input int port, input bit wr, input wbAdrT adr, input selT sel,
                            input wordT data, input bit hold, output int cycles);
      bit          valid;
      bit          done;
      ramAdrT      word;
      logic [33:0] entry;
      valid = (adr < 32'h0000_1000) && (adr[1:0] == 2'b00);   // 4 KiB window, aligned
      word  = adr[11:2];
      done  = 1'b0;
      if (valid && wr) begin
         shadow[word] = mergeBytes(shadow[word], data, sel);
      end
      entry = {!valid, !wr, shadow[word]};
      if (port == 0) begin
         expA.push_back(entry);
      end else begin
         expB.push_back(entry);
      end
      driveBus(port, 1'b1, wr, adr, sel, data);
      cycles = 0;
      while (!done && cycles < 20) begin
         @(posedge clk);
         #0.5;
         cycles++;
         done = (port == 0) ? (ackA || errA) : (ackB || errB);
      end
      if (!done) begin
         errorCount++;
         $display("Port %s gave neither ack nor err within 20 cycles at %0.1f ns",
                  (port == 0) ? "A" : "B", $realtime);
         cycles = -1;
      end
      if (!hold || !done) begin
         driveBus(port, 1'b0, 1'b0, '0, '0, '0);
         @(posedge clk);   // Port is idle again before the next request
         #0.5;
      end
   endtask

   task automatic writeWord(input int port, input wbAdrT adr, input selT sel, input wordT data);
      int cycles;
      busAccess(port, 1'b1, adr, sel, data, 1'b0, cycles);
   endtask

   task automatic readWord(input int port, input wbAdrT adr);
      int cycles;
      busAccess(port, 1'b0, adr, 4'hF, '0, 1'b0, cycles);
   endtask

   // Pattern built from the whole word address
   task automatic fillHalf(input int port, input int firstWord);
      ramAdrT word;
      for (int i = 0; i < 512; i++) begin
         word = ramAdrT'(firstWord + i);
         writeWord(port, {20'h0, word, 2'b00}, 4'hF, {6'h2a, ~word, 6'h15, word});
      end
   endtask

   task automatic partialWrites(input int port, input wbAdrT adr);
      for (int s = 0; s < 16; s++) begin
         writeWord(port, adr, selT'(s), $urandom);
         readWord(port, adr);
      end
   endtask

   task automatic randomTraffic(input int port, input int firstWord);
      ramAdrT word;
      for (int i = 0; i < 100; i++) begin
         word = ramAdrT'(firstWord + ($urandom % 512));
         if ($urandom % 2) begin
            writeWord(port, {20'h0, word, 2'b00}, selT'($urandom), $urandom);
         end else begin
            readWord(port, {20'h0, word, 2'b00});
         end
      end
   endtask

   // stb stays high between accesses, write then read of each word
   task automatic chainAccesses(input int port, input int firstWord);
      int    cycles;
      wbAdrT adr;
      for (int i = 0; i < 8; i++) begin
         adr = {20'h0, ramAdrT'(firstWord + i / 2), 2'b00};
         busAccess(port, (i % 2) == 0, adr, 4'hF, $urandom, i < 7, cycles);
         compare((port == 0) ? "latency A" : "latency B", cycles, (i == 0) ? 1 : 2);
      end
   endtask

   task automatic checkResponse(input string port, input logic ack, input logic err,
                                input wordT datR, input logic [33:0] entry);
      compare({"ack", port}, ack, !entry[33]);
      compare({"err", port}, err, entry[33]);
      if (entry[32] && !entry[33]) begin
         compare({"datR", port}, datR, entry[31:0]);
      end
   endtask

   task automatic endTest(input int num, input string name, input int errBefore);
      if (errorCount == errBefore) begin
         $display("Test %0d, %s: ok", num, name);
      end else begin
         testsFailed++;
         $display("Test %0d, %s: %0d errors", num, name, errorCount - errBefore);
      end
   endtask

   // Responses checked mid-cycle, where ack, err and datR are stable
   always @(negedge clk) begin
      if ((ackA || errA) && expA.size() == 0) begin
         errorCount++;
         $display("Port A responded at %0.1f ns with no access pending", $realtime);
      end else if (ackA || errA) begin
         checkResponse("A", ackA, errA, datRA, expA.pop_front());
      end
      if ((ackB || errB) && expB.size() == 0) begin
         errorCount++;
         $display("Port B responded at %0.1f ns with no access pending", $realtime);
      end else if (ackB || errB) begin
         checkResponse("B", ackB, errB, datRB, expB.pop_front());
      end
   end

   initial begin : main
      int errBefore;
      int cycles;
      seedResult = $urandom(18949);
      clk   = 1'b0;
      arstN = 1'b0;
      driveBus(0, 1'b0, 1'b0, '0, '0, '0);
      driveBus(1, 1'b0, 1'b0, '0, '0, '0);
      repeat (8) @(posedge clk);
      #0.5;
      arstN = 1'b1;

      errBefore = errorCount;
      compare("ackA", ackA, 1'b0);
      compare("errA", errA, 1'b0);
      compare("ackB", ackB, 1'b0);
      compare("errB", errB, 1'b0);
      busAccess(0, 1'b1, 32'h0000_0040, 4'hF, $urandom, 1'b0, cycles);
      compare("latency A", cycles, 1);
      busAccess(0, 1'b0, 32'h0000_0040, 4'hF, '0, 1'b0, cycles);
      compare("latency A", cycles, 1);
      busAccess(1, 1'b1, 32'h0000_0a00, 4'hF, $urandom, 1'b0, cycles);
      compare("latency B", cycles, 1);
      busAccess(1, 1'b0, 32'h0000_0a00, 4'hF, '0, 1'b0, cycles);
      compare("latency B", cycles, 1);
      endTest(1, "reset and full-word access", errBefore);

      errBefore = errorCount;
      fork
         fillHalf(0, 0);
         fillHalf(1, 512);
      join
      fork
         partialWrites(0, 32'h0000_0050);
         partialWrites(1, 32'h0000_0c50);
      join
      endTest(2, "byte select writes", errBefore);

      errBefore = errorCount;
      writeWord(0, 32'h0000_0190, 4'hF, $urandom);
      readWord(1, 32'h0000_0190);
      writeWord(1, 32'h0000_0b00, 4'hF, $urandom);
      readWord(0, 32'h0000_0b00);
      endTest(3, "cross-port read-back", errBefore);

      errBefore = errorCount;
      writeWord(0, 32'h0000_1000, 4'hF, 32'hdead_beef);   // First word past the window
      readWord(1, 32'h0000_1000);
      writeWord(1, 32'h0000_0052, 4'hF, 32'hdead_beef);
      readWord(0, 32'h0000_0053);
      writeWord(0, 32'hffff_fffc, 4'hF, 32'h1234_5678);
      readWord(0, 32'h0000_0000);   // Aliased words keep their contents
      readWord(1, 32'h0000_0050);
      readWord(0, 32'h0000_0ffc);
      endTest(4, "range and alignment errors", errBefore);

      errBefore = errorCount;
      fork
         randomTraffic(0, 0);
         randomTraffic(1, 512);
      join
      endTest(5, "concurrent random traffic", errBefore);

      errBefore = errorCount;
      fork
         chainAccesses(0, 300);
         chainAccesses(1, 900);
      join
      endTest(6, "back-to-back accesses", errBefore);

      repeat (2) @(posedge clk);
      if (expA.size() != 0 || expB.size() != 0) begin
         errorCount++;
         $display("%0d responses never arrived", expA.size() + expB.size());
      end
      $display("Tests failed %0d of 6, checks %0d, errors %0d",
               testsFailed, checkCount, errorCount);
      if (errorCount == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- vlog.f
hdl/dpMemPkg.sv
hdl/tdpRamCol.sv
hdl/tdpRamBe.sv
hdl/wbMemPort.sv
hdl/dualPortWbMem.sv
tb/tbDualPortWbMem.sv
